//--- list.f
src/soc_pkg.sv
src/rst_seq.sv
src/bus_router.sv
src/dev_table.sv
src/gpio_port.sv
src/soc_top.sv
testbench/tb_soc_top.sv

//--- src/bus_router.sv
// Bus router for the peripheral map
// Address decode, op steering to slaves, read data return
// Addresses past the last slave go to an invalid device that reads zero
`timescale 1ns/1ns
`default_nettype none

module bus_router import soc_pkg::*; (
	input  wire                                  clk200mhz_w,
	input  wire                                  sys_rst_i,
	input  pi1_op_t                              pi1_op_i,
	input  wire     [ADDR_W-1:0]                 pi1_addr_i,
	input  wire     [DATA_W-1:0]                 pi1_data_i,
	input  wire     [SEL_W-1:0]                  pi1_sel_i,
	output logic    [DATA_W-1:0]                 pi1_data_o,
	output wire                                  pi1_rdy_o,
	output pi1_op_t                              devtbl_op_o,
	output wire     [$clog2(DEVTBL_MAPSZ)-1:0]   devtbl_addr_o,
	input  wire     [DATA_W-1:0]                 devtbl_data_i,
	output pi1_op_t                              gpio_op_o,
	output wire     [$clog2(GPIO_MAPSZ)-1:0]     gpio_addr_o,
	input  wire     [DATA_W-1:0]                 gpio_data_i,
	output wire     [DATA_W-1:0]                 wdata_o,
	output wire     [SEL_W-1:0]                  sel_o
);

	localparam int DEVTBL_AW = $clog2(DEVTBL_MAPSZ);
	localparam int GPIO_AW   = $clog2(GPIO_MAPSZ);

	// Slot bases from the cumulative map sizes
	localparam logic [ADDR_W-1:0] DEVTBL_BASE  = '0;
	localparam logic [ADDR_W-1:0] GPIO_BASE    = ADDR_W'(DEVTBL_MAPSZ);
	localparam logic [ADDR_W-1:0] INVALID_BASE = ADDR_W'(DEVTBL_MAPSZ + GPIO_MAPSZ);

	slv_idx_t slot_w;
	slv_idx_t slot_q;
	logic     acc_w;

	always_comb begin
		if (pi1_addr_i < GPIO_BASE)
			slot_w = SLV_DEVTBL;
		else if (pi1_addr_i < INVALID_BASE)
			slot_w = SLV_GPIO;
		else
			slot_w = SLV_INVALID;
	end

	// No slave stalls, so the bus is ready whenever the system is out of reset
	assign pi1_rdy_o = ~sys_rst_i;
	assign acc_w     = pi1_rdy_o && (pi1_op_i != PI1_NONE);

	assign devtbl_op_o = (acc_w && slot_w == SLV_DEVTBL) ? pi1_op_i : PI1_NONE;
	assign gpio_op_o   = (acc_w && slot_w == SLV_GPIO) ? pi1_op_i : PI1_NONE;

	// Local word address within each slave
	assign devtbl_addr_o = DEVTBL_AW'(pi1_addr_i - DEVTBL_BASE);
	assign gpio_addr_o   = GPIO_AW'(pi1_addr_i - GPIO_BASE);

	assign wdata_o = pi1_data_i;
	assign sel_o   = pi1_sel_i;

	// Slot of the last accepted op picks the returning data
	always_ff @(posedge clk200mhz_w) begin
		if (sys_rst_i)
			slot_q <= SLV_INVALID;
		else if (acc_w)
			slot_q <= slot_w;
	end

	always_comb begin
		case (slot_q)
			SLV_DEVTBL: pi1_data_o = devtbl_data_i;
			SLV_GPIO:   pi1_data_o = gpio_data_i;
			// Invalid device, writes dropped and reads return zero
			default:    pi1_data_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/dev_table.sv
// Device table slave
// Per-slot id, map size and interrupt flag, read-only
// Software reset request word
`timescale 1ns/1ns
`default_nettype none

module dev_table import soc_pkg::*; (
	input  wire                clk200mhz_w,
	input  wire                sys_rst_i,
	input  pi1_op_t            op_i,
	input  wire   [3:0]        addr_i,
	input  wire   [DATA_W-1:0] data_i,
	input  wire   [SEL_W-1:0]  sel_i,
	output logic  [DATA_W-1:0] data_o,
	output wire                rst0_o,
	output wire                rst1_o
);

	localparam logic [DATA_W-1:0] SLOT_ID [DEV_COUNT] = '{
		DATA_W'(DEVTBL_ID), DATA_W'(GPIO_ID), DATA_W'(INVALID_ID)
	};
	localparam logic [DATA_W-1:0] SLOT_MAPSZ [DEV_COUNT] = '{
		DATA_W'(DEVTBL_MAPSZ), DATA_W'(GPIO_MAPSZ), DATA_W'(INVALID_MAPSZ)
	};
	// Only GPIO raises an interrupt
	localparam logic [DEV_COUNT-1:0] SLOT_INTR = DEV_COUNT'(1) << SLV_GPIO;

	// Bit 0 is rst1, bit 1 is rst0
	logic [1:0]        rst_req_q;
	logic [DATA_W-1:0] rd_word;
	logic              wr_w;
	logic              rd_w;

	assign wr_w = (op_i == PI1_WRITE) || (op_i == PI1_RDWR);
	assign rd_w = (op_i == PI1_READ) || (op_i == PI1_RDWR);

	// Word 2k is the id of slot k, word 2k+1 its map size
	always_comb begin
		rd_word = '0;
		for (int k = 0; k < DEV_COUNT; k++) begin
			if (addr_i == 4'(2 * k))
				rd_word = SLOT_ID[k];
			else if (addr_i == 4'(2 * k + 1))
				rd_word = SLOT_MAPSZ[k] | {SLOT_INTR[k], {(DATA_W-1){1'b0}}};
		end
		if (addr_i == 4'(RSTREQ_WORD))
			rd_word = {{(DATA_W-2){1'b0}}, rst_req_q};
	end

	// Cleared by system reset, so a warm request clears itself
	always_ff @(posedge clk200mhz_w) begin
		if (sys_rst_i)
			rst_req_q <= 2'b00;
		else if (wr_w && addr_i == 4'(RSTREQ_WORD) && sel_i[0])
			rst_req_q <= data_i[1:0];
	end

	always_ff @(posedge clk200mhz_w) begin
		if (rd_w)
			data_o <= rd_word;
	end

	assign rst1_o = rst_req_q[0];
	assign rst0_o = rst_req_q[1];

endmodule

`default_nettype wire

//--- src/gpio_port.sv
// GPIO slave
// Two-stage input sync, byte-writable outputs, change status and mask
`timescale 1ns/1ns
`default_nettype none

module gpio_port import soc_pkg::*; #(
	parameter int GPIO_COUNT = 8
) (
	input  wire                    clk200mhz_w,
	input  wire                    sys_rst_i,
	input  pi1_op_t                op_i,
	input  wire   [1:0]            addr_i,
	input  wire   [DATA_W-1:0]     data_i,
	input  wire   [SEL_W-1:0]      sel_i,
	output logic  [DATA_W-1:0]     data_o,
	input  wire   [GPIO_COUNT-1:0] gp_i,
	output wire   [GPIO_COUNT-1:0] gp_o,
	output wire                    int_o
);

	logic [GPIO_COUNT-1:0] sync1_q;
	logic [GPIO_COUNT-1:0] sync2_q;
	logic [GPIO_COUNT-1:0] prev_q;
	logic [GPIO_COUNT-1:0] out_q;
	logic [GPIO_COUNT-1:0] mask_q;
	logic [GPIO_COUNT-1:0] stat_q;
	logic [GPIO_COUNT-1:0] bmask;
	logic [GPIO_COUNT-1:0] wval;
	logic [DATA_W-1:0]     rd_word;
	logic                  wr_w;
	logic                  rd_w;

	assign wr_w = (op_i == PI1_WRITE) || (op_i == PI1_RDWR);
	assign rd_w = (op_i == PI1_READ) || (op_i == PI1_RDWR);
	assign wval = data_i[GPIO_COUNT-1:0];

	// Each pin follows the sel bit of its byte
	always_comb begin
		for (int i = 0; i < GPIO_COUNT; i++)
			bmask[i] = sel_i[i / 8];
	end

	always_ff @(posedge clk200mhz_w) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	always_ff @(posedge clk200mhz_w) begin
		if (sys_rst_i) begin
			out_q  <= '0;
			mask_q <= '0;
			stat_q <= '0;
		end else begin
			if (wr_w && addr_i == 2'd1)
				out_q <= (out_q & ~bmask) | (wval & bmask);
			if (wr_w && addr_i == 2'd2)
				mask_q <= (mask_q & ~bmask) | (wval & bmask);
			// A new change wins over a clear in the same cycle
			if (wr_w && addr_i == 2'd3)
				stat_q <= (stat_q & ~(wval & bmask)) | (sync2_q ^ prev_q);
			else
				stat_q <= stat_q | (sync2_q ^ prev_q);
		end
	end

	always_comb begin
		case (addr_i)
			2'd0:    rd_word = DATA_W'(sync2_q);
			2'd1:    rd_word = DATA_W'(out_q);
			2'd2:    rd_word = DATA_W'(mask_q);
			default: rd_word = DATA_W'(stat_q);
		endcase
	end

	// Swap returns the value from before the write
	always_ff @(posedge clk200mhz_w) begin
		if (rd_w)
			data_o <= rd_word;
	end

	assign gp_o  = out_q;
	assign int_o = |(stat_q & mask_q);

endmodule

`default_nettype wire

//--- src/rst_seq.sv
// Reset sequencer
// Reload counter for external and warm reset, power-off latch
`timescale 1ns/1ns
`default_nettype none

module rst_seq #(
	parameter int RST_CNTR_W = 20
) (
	input  wire clk200mhz_w,
	input  wire rst_p,
	input  wire rst0_i,
	input  wire rst1_i,
	output wire sys_rst_o
);

	logic [RST_CNTR_W-1:0] cntr_q;
	logic                  pwroff_q;
	logic                  warm_w;
	logic                  pwroff_w;

	// Both bits together would be a cold reset, not supported here
	assign warm_w   = rst1_i & ~rst0_i;
	assign pwroff_w = rst0_i & ~rst1_i;

	// Counter holds at all ones while a reset source is present
	always_ff @(posedge clk200mhz_w) begin
		if (rst_p || warm_w)
			cntr_q <= '1;
		else if (|cntr_q)
			cntr_q <= cntr_q - 1'b1;
	end

	// Power-off stays until the board reset is pressed again
	always_ff @(posedge clk200mhz_w) begin
		if (rst_p)
			pwroff_q <= 1'b0;
		else if (pwroff_w)
			pwroff_q <= 1'b1;
	end

	assign sys_rst_o = rst_p | (|cntr_q) | pwroff_q;

endmodule

`default_nettype wire

//--- src/soc_pkg.sv
// Shared definitions for the peripheral bus
// Bus opcodes, slave slots, bus widths, map sizes and device ids
`default_nettype none

package soc_pkg;

	// Bus opcodes, RDWR returns the old word and writes the new one
	typedef enum logic [1:0] {
		PI1_NONE  = 2'd0,
		PI1_WRITE = 2'd1,
		PI1_READ  = 2'd2,
		PI1_RDWR  = 2'd3
	} pi1_op_t;

	// Slave slots in map order
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_GPIO    = 2'd1,
		SLV_INVALID = 2'd2
	} slv_idx_t;

	// Bus widths, address counts words
	localparam int DATA_W = 32;
	localparam int ADDR_W = 30;
	localparam int SEL_W  = 4;

	// Map sizes in words, slaves are packed from address 0
	localparam int DEVTBL_MAPSZ  = 16;
	localparam int GPIO_MAPSZ    = 4;
	localparam int INVALID_MAPSZ = 1024;

	// Device table contents
	localparam int DEV_COUNT  = 3;
	localparam int DEVTBL_ID  = 7;
	localparam int GPIO_ID    = 6;
	localparam int INVALID_ID = 0;

	// Word holding the software reset request bits
	localparam int RSTREQ_WORD = 15;

endpackage

`default_nettype wire

//--- src/soc_top.sv
// Peripheral SoC top level
// Reset sequencer, bus router, device table and GPIO
`timescale 1ns/1ns
`default_nettype none

module soc_top import soc_pkg::*; #(
	parameter int GPIO_COUNT = 8,
	parameter int RST_CNTR_W = 20
) (
	input  wire                    clk200mhz_w,
	input  wire                    rst_p,
	input  pi1_op_t                pi1_op_i,
	input  wire   [ADDR_W-1:0]     pi1_addr_i,
	input  wire   [DATA_W-1:0]     pi1_data_i,
	input  wire   [SEL_W-1:0]      pi1_sel_i,
	output wire   [DATA_W-1:0]     pi1_data_o,
	output wire                    pi1_rdy_o,
	input  wire   [GPIO_COUNT-1:0] gp_i,
	output wire   [GPIO_COUNT-1:0] gp_o,
	output wire                    int_o
);

	wire                             sys_rst_w;
	wire                             rst0_w;
	wire                             rst1_w;
	pi1_op_t                         devtbl_op_w;
	wire [$clog2(DEVTBL_MAPSZ)-1:0]  devtbl_addr_w;
	wire [DATA_W-1:0]                devtbl_rdata_w;
	pi1_op_t                         gpio_op_w;
	wire [$clog2(GPIO_MAPSZ)-1:0]    gpio_addr_w;
	wire [DATA_W-1:0]                gpio_rdata_w;
	wire [DATA_W-1:0]                wdata_w;
	wire [SEL_W-1:0]                 sel_w;

	rst_seq #(
		.RST_CNTR_W (RST_CNTR_W)
	) u_rst_seq (
		 .clk200mhz_w (clk200mhz_w)
		,.rst_p       (rst_p)
		,.rst0_i      (rst0_w)
		,.rst1_i      (rst1_w)
		,.sys_rst_o   (sys_rst_w)
	);

	bus_router u_bus_router (
		 .clk200mhz_w   (clk200mhz_w)
		,.sys_rst_i     (sys_rst_w)
		,.pi1_op_i      (pi1_op_i)
		,.pi1_addr_i    (pi1_addr_i)
		,.pi1_data_i    (pi1_data_i)
		,.pi1_sel_i     (pi1_sel_i)
		,.pi1_data_o    (pi1_data_o)
		,.pi1_rdy_o     (pi1_rdy_o)
		,.devtbl_op_o   (devtbl_op_w)
		,.devtbl_addr_o (devtbl_addr_w)
		,.devtbl_data_i (devtbl_rdata_w)
		,.gpio_op_o     (gpio_op_w)
		,.gpio_addr_o   (gpio_addr_w)
		,.gpio_data_i   (gpio_rdata_w)
		,.wdata_o       (wdata_w)
		,.sel_o         (sel_w)
	);

	dev_table u_dev_table (
		 .clk200mhz_w (clk200mhz_w)
		,.sys_rst_i   (sys_rst_w)
		,.op_i        (devtbl_op_w)
		,.addr_i      (devtbl_addr_w)
		,.data_i      (wdata_w)
		,.sel_i       (sel_w)
		,.data_o      (devtbl_rdata_w)
		,.rst0_o      (rst0_w)
		,.rst1_o      (rst1_w)
	);

	gpio_port #(
		.GPIO_COUNT (GPIO_COUNT)
	) u_gpio_port (
		 .clk200mhz_w (clk200mhz_w)
		,.sys_rst_i   (sys_rst_w)
		,.op_i        (gpio_op_w)
		,.addr_i      (gpio_addr_w)
		,.data_i      (wdata_w)
		,.sel_i       (sel_w)
		,.data_o      (gpio_rdata_w)
		,.gp_i        (gp_i)
		,.gp_o        (gp_o)
		,.int_o       (int_o)
	);

endmodule

`default_nettype wire

//--- testbench/tb_soc_top.sv
// Testbench for the peripheral SoC top level
// Bus master tasks, LFSR stimulus, concurrent and immediate assertions
`timescale 1ns/1ns
`default_nettype none

module tb_soc_top import soc_pkg::*; ();

	localparam int GPIO_COUNT = 8;

	logic                  clk200mhz_w;
	logic                  rst_p;
	pi1_op_t               pi1_op_i;
	logic [ADDR_W-1:0]     pi1_addr_i;
	logic [DATA_W-1:0]     pi1_data_i;
	logic [SEL_W-1:0]      pi1_sel_i;
	logic [DATA_W-1:0]     pi1_data_o;
	logic                  pi1_rdy_o;
	logic [GPIO_COUNT-1:0] gp_i;
	logic [GPIO_COUNT-1:0] gp_o;
	logic                  int_o;
	logic [31:0]           lfsr;
	int                    errors;
	int                    timeouts;

	soc_top #(
		.GPIO_COUNT (GPIO_COUNT),
		.RST_CNTR_W (4)
	) dut (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.pi1_op_i    (pi1_op_i),
		.pi1_addr_i  (pi1_addr_i),
		.pi1_data_i  (pi1_data_i),
		.pi1_sel_i   (pi1_sel_i),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.gp_i        (gp_i),
		.gp_o        (gp_o),
		.int_o       (int_o)
	);

	initial begin
		clk200mhz_w = 1'b0;
		forever #2 clk200mhz_w = ~clk200mhz_w;
	end

	// System reset holds for 15 cycles after the board reset falls
	assert property (@(posedge clk200mhz_w) $fell(rst_p) |-> !pi1_rdy_o [*15] ##1 pi1_rdy_o)
	else begin
		errors++;
		$display("ERROR at %0t: bus ready not released 15 cycles after reset", $time);
	end

	// Outputs are quiet once system reset has taken effect
	assert property (@(posedge clk200mhz_w) disable iff (rst_p)
		(!pi1_rdy_o && !$fell(pi1_rdy_o)) |-> (gp_o == '0 && !int_o))
	else begin
		errors++;
		$display("ERROR at %0t: gp_o %h int_o %b during system reset", $time, gp_o, int_o);
	end

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Id and map size per slot with GPIO flagged as interrupt user
	function automatic logic [31:0] table_word(input int w);
		case (w)
			0:       return 32'd7;
			1:       return 32'd16;
			2:       return 32'd6;
			3:       return 32'h8000_0004;
			5:       return 32'd1024;
			default: return 32'd0;
		endcase
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp)
		else begin
			errors++;
			$display("ERROR at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		timeouts++;
		$display("Timed out at %0t waiting for %s", $time, what);
	endtask

	// Sampled at falling edges where ready is stable
	task automatic wait_level(input logic level, input int limit, output bit ok);
		int n;
		n = 0;
		@(negedge clk200mhz_w);
		while (pi1_rdy_o !== level && n < limit) begin
			n++;
			@(negedge clk200mhz_w);
		end
		ok = (pi1_rdy_o === level);
	endtask

	task automatic bus_op(input pi1_op_t op, input int addr, input logic [31:0] wd,
		input logic [3:0] sel, output logic [31:0] rd);
		bit ok;
		@(posedge clk200mhz_w);
		#1;
		pi1_op_i   = op;
		pi1_addr_i = ADDR_W'(addr);
		pi1_data_i = wd;
		pi1_sel_i  = sel;
		wait_level(1'b1, 100, ok);
		if (!ok)
			note_timeout("bus ready before an op");
		@(posedge clk200mhz_w);
		#1;
		pi1_op_i = PI1_NONE;
		// Read data is valid in the cycle after acceptance
		@(negedge clk200mhz_w);
		rd = pi1_data_o;
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] d;
		logic [31:0] s;
		logic [7:0]  out_exp;
		logic [7:0]  pat;
		logic [7:0]  bit_m;
		bit          ok;
		errors     = 0;
		timeouts   = 0;
		lfsr       = 32'h348d_bee5;
		rst_p      = 1'b1;
		pi1_op_i   = PI1_NONE;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i  = '0;
		gp_i       = '0;
		repeat (2) @(posedge clk200mhz_w);
		#1;
		rst_p = 1'b0;
		wait_level(1'b1, 40, ok);
		if (!ok)
			note_timeout("bus ready after power-on reset");

		for (int w = 0; w < 16; w++) begin
			bus_op(PI1_READ, w, 32'd0, 4'h0, rd);
			check_eq(rd, table_word(w), "device table word");
		end

		// Output writes with random byte selects
		out_exp = '0;
		for (int n = 0; n < 4; n++) begin
			take_bits(8, d);
			take_bits(4, s);
			bus_op(PI1_WRITE, 17, d, s[3:0], rd);
			if (s[0])
				out_exp = d[7:0];
			check_eq(gp_o, out_exp, "gp_o after byte write");
		end
		bus_op(PI1_WRITE, 17, {24'd0, ~out_exp}, 4'he, rd);
		check_eq(gp_o, out_exp, "gp_o with byte 0 unselected");
		out_exp = ~out_exp;
		bus_op(PI1_WRITE, 17, {24'd0, out_exp}, 4'h1, rd);
		check_eq(gp_o, out_exp, "gp_o with byte 0 selected");
		take_bits(8, d);
		bus_op(PI1_RDWR, 17, d, 4'hf, rd);
		check_eq(rd, out_exp, "swap old value");
		check_eq(gp_o, d[7:0], "gp_o after swap");
		bus_op(PI1_RDWR, 17, 32'ha5, 4'hf, rd);
		check_eq(rd, d[7:0], "second swap old value");
		out_exp = 8'ha5;

		// Input sync, change status and interrupt
		bus_op(PI1_WRITE, 18, 32'd0, 4'hf, rd);
		take_bits(8, d);
		pat = (d[7:0] == 8'd0) ? 8'h80 : d[7:0];
		@(posedge clk200mhz_w);
		#1;
		gp_i = pat;
		repeat (4) @(posedge clk200mhz_w);
		bus_op(PI1_READ, 16, 32'd0, 4'h0, rd);
		check_eq(rd, pat, "synchronized input");
		bus_op(PI1_READ, 19, 32'd0, 4'h0, rd);
		check_eq(rd, pat, "change status");
		check_eq(int_o, 1'b0, "int_o with mask clear");
		bit_m = pat & (~pat + 8'd1);
		bus_op(PI1_WRITE, 18, bit_m, 4'h1, rd);
		check_eq(int_o, 1'b1, "int_o with mask set");
		bus_op(PI1_WRITE, 19, bit_m, 4'h1, rd);
		check_eq(int_o, 1'b0, "int_o after status clear");
		bus_op(PI1_READ, 19, 32'd0, 4'h0, rd);
		check_eq(rd, pat & ~bit_m, "status after clear");

		// The GPIO read leaves nonzero data on the return path before the invalid reads
		bus_op(PI1_READ, 17, 32'd0, 4'h0, rd);
		check_eq(rd, out_exp, "gp_o readback");
		bus_op(PI1_READ, 20, 32'd0, 4'h0, rd);
		check_eq(rd, 32'd0, "invalid device word 20");
		take_bits(10, d);
		bus_op(PI1_READ, 20 + int'(d[9:0]), 32'd0, 4'h0, rd);
		check_eq(rd, 32'd0, "invalid device random word");
		bus_op(PI1_WRITE, 21, 32'hffff_ffff, 4'hf, rd);
		bus_op(PI1_WRITE, 22, 32'hffff_ffff, 4'hf, rd);
		bus_op(PI1_WRITE, 31, 32'hffff_ffff, 4'hf, rd);
		check_eq(gp_o, out_exp, "gp_o after invalid writes");
		bus_op(PI1_READ, 15, 32'd0, 4'h0, rd);
		check_eq(rd, 32'd0, "reset word after invalid writes");
		bus_op(PI1_READ, 18, 32'd0, 4'h0, rd);
		check_eq(rd, bit_m, "mask after invalid writes");

		// Dropping the inputs again leaves a masked status bit pending
		@(posedge clk200mhz_w);
		#1;
		gp_i = '0;
		repeat (4) @(posedge clk200mhz_w);
		@(negedge clk200mhz_w);
		check_eq(int_o, 1'b1, "int_o pending before warm reset");

		// Warm reset through rst1
		bus_op(PI1_WRITE, 15, 32'd1, 4'h1, rd);
		wait_level(1'b0, 10, ok);
		if (!ok)
			note_timeout("bus ready to drop on warm reset");
		wait_level(1'b1, 100, ok);
		if (!ok)
			note_timeout("bus ready after warm reset");
		check_eq(gp_o, 8'd0, "gp_o after warm reset");
		bus_op(PI1_READ, 15, 32'd0, 4'h0, rd);
		check_eq(rd, 32'd0, "reset word after warm reset");

		// Power-off through rst0 holds until the board reset
		bus_op(PI1_WRITE, 15, 32'd2, 4'h1, rd);
		wait_level(1'b0, 10, ok);
		if (!ok)
			note_timeout("bus ready to drop on power-off");
		wait_level(1'b1, 100, ok);
		assert (!ok)
		else begin
			errors++;
			$display("ERROR at %0t: bus ready returned during power-off", $time);
		end
		@(posedge clk200mhz_w);
		#1;
		rst_p = 1'b1;
		repeat (2) @(posedge clk200mhz_w);
		#1;
		rst_p = 1'b0;
		wait_level(1'b1, 40, ok);
		if (!ok)
			note_timeout("bus ready after board reset");
		bus_op(PI1_READ, 15, 32'd0, 4'h0, rd);
		check_eq(rd, 32'd0, "reset word after board reset");

		$display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
